// ==== source/uart_pkg.sv ====
package uart_pkg;

    // System clock and line rate
    localparam int clk_freq  = 50_000_000;
    localparam int baud_rate = 115_200;

    // Clock cycles per bit, 434 at these rates
    localparam int baud_div      = clk_freq / baud_rate;
    localparam int baud_div_half = baud_div / 2;  // Delay to centre of start bit

    // Width of the baud counters in both halves
    localparam int baud_cnt_w = $clog2(baud_div);

    typedef logic [baud_cnt_w-1:0] baud_cnt_t;

    // Terminal counts, already sized to the counter
    localparam baud_cnt_t baud_last      = baud_cnt_t'(baud_div - 1);
    localparam baud_cnt_t baud_half_last = baud_cnt_t'(baud_div_half - 1);

    // Transmit FSM
    typedef enum logic [2:0] {
        tx_idle,
        tx_start,
        tx_data,
        tx_parity,  // Only when bit 8 of the word was set
        tx_stop1,
        tx_stop2
    } tx_state_t;

    // Receive FSM
    typedef enum logic [2:0] {
        rx_idle,
        rx_start,   // Waiting for mid start bit
        rx_data,
        rx_parity,
        rx_stop1,
        rx_stop2
    } rx_state_t;

endpackage

// ==== source/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
    input  logic       clk,
    input  logic       rst,
    input  logic       uart_start,  // One-cycle strobe, taken only when ready
    input  logic [8:0] data_in,     // Bit 8 turns parity on for this frame
    output logic       tx,
    output logic       uart_ready,
    output logic       uart_busy
);

    import uart_pkg::*;

    tx_state_t state;
    tx_state_t next_state;

    baud_cnt_t  baud_cnt;
    logic       baud_tick;
    logic [2:0] bit_cnt;
    logic [7:0] shift_reg;
    logic       parity_on;
    logic       parity_bit;
    logic       accept;

    assign accept    = (state == tx_idle) && uart_start;
    assign baud_tick = (baud_cnt == baud_last);

    // Counter is held at zero in idle so each frame starts on a full bit
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            baud_cnt <= '0;
        end else if (state == tx_idle || baud_tick) begin
            baud_cnt <= '0;
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= tx_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            tx_idle: begin
                if (uart_start) begin
                    next_state = tx_start;
                end
            end
            tx_start: begin
                if (baud_tick) begin
                    next_state = tx_data;
                end
            end
            tx_data: begin
                // Eighth bit done, parity is optional
                if (baud_tick && bit_cnt == 3'd7) begin
                    next_state = parity_on ? tx_parity : tx_stop1;
                end
            end
            tx_parity: begin
                if (baud_tick) begin
                    next_state = tx_stop1;
                end
            end
            tx_stop1: begin
                if (baud_tick) begin
                    next_state = tx_stop2;
                end
            end
            tx_stop2: begin
                if (baud_tick) begin
                    next_state = tx_idle;
                end
            end
            default: next_state = tx_idle;
        endcase
    end

    // Frame control captured at the accepted strobe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            parity_on <= 1'b0;
            bit_cnt   <= 3'd0;
        end else if (accept) begin
            parity_on <= data_in[8];
            bit_cnt   <= 3'd0;
        end else if (state == tx_data && baud_tick) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // Payload, LSB goes out first
    always_ff @(posedge clk) begin
        if (accept) begin
            shift_reg  <= data_in[7:0];
            parity_bit <= ^data_in[7:0];  // Even parity
        end else if (state == tx_data && baud_tick) begin
            shift_reg <= {1'b0, shift_reg[7:1]};
        end
    end

    // Registered line, lags the state by one cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx <= 1'b1;
        end else begin
            case (state)
                tx_start:  tx <= 1'b0;
                tx_data:   tx <= shift_reg[0];
                tx_parity: tx <= parity_bit;
                default:   tx <= 1'b1;  // Idle and both stop bits
            endcase
        end
    end

    assign uart_ready = (state == tx_idle);
    assign uart_busy  = (state != tx_idle);

endmodule

// ==== source/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx (
    input  logic       clk,
    input  logic       rst,
    input  logic       rx,          // Asynchronous serial input
    input  logic       parity_en,   // Sampled as the receiver leaves idle
    output logic [8:0] data_out,    // Parity flag and the received byte
    output logic       rx_valid,
    output logic       uart_error
);

    import uart_pkg::*;

    rx_state_t state;
    rx_state_t next_state;

    logic       rx_meta;
    logic       rx_sync;
    baud_cnt_t  baud_cnt;
    logic       baud_tick;
    logic [2:0] bit_cnt;
    logic [7:0] shift_reg;
    logic       parity_on;
    logic       parity_err;
    logic       frame_err;
    logic       frame_start;

    // Two flops, reset to the idle line level
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    assign frame_start = (state == rx_idle) && !rx_sync;

    // Half a bit in the start state, then a full bit per sample
    assign baud_tick = (state == rx_start) ? (baud_cnt == baud_half_last)
                                           : (baud_cnt == baud_last);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            baud_cnt <= '0;
        end else if (state == rx_idle || baud_tick) begin
            baud_cnt <= '0;
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= rx_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            rx_idle: begin
                if (!rx_sync) begin
                    next_state = rx_start;
                end
            end
            rx_start: begin
                // Line back high at mid-bit means a glitch
                if (baud_tick) begin
                    next_state = rx_sync ? rx_idle : rx_data;
                end
            end
            rx_data: begin
                if (baud_tick && bit_cnt == 3'd7) begin
                    next_state = parity_on ? rx_parity : rx_stop1;
                end
            end
            rx_parity: begin
                if (baud_tick) begin
                    next_state = rx_stop1;
                end
            end
            rx_stop1: begin
                if (baud_tick) begin
                    next_state = rx_stop2;
                end
            end
            rx_stop2: begin
                if (baud_tick) begin
                    next_state = rx_idle;
                end
            end
            default: next_state = rx_idle;
        endcase
    end

    // Byte assembly, LSB arrives first
    always_ff @(posedge clk) begin
        if (state == rx_data && baud_tick) begin
            shift_reg <= {rx_sync, shift_reg[7:1]};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bit_cnt   <= 3'd0;
            parity_on <= 1'b0;
        end else if (frame_start) begin
            bit_cnt   <= 3'd0;
            parity_on <= parity_en;
        end else if (state == rx_data && baud_tick) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // Errors are sticky for the whole frame and the idle time after it
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            parity_err <= 1'b0;
            frame_err  <= 1'b0;
        end else if (frame_start) begin
            parity_err <= 1'b0;
            frame_err  <= 1'b0;
        end else if (baud_tick) begin
            case (state)
                rx_parity: parity_err <= (^shift_reg) != rx_sync;
                rx_stop1,
                rx_stop2: begin
                    if (!rx_sync) begin
                        frame_err <= 1'b1;  // Stop bit seen low
                    end
                end
                default: ;
            endcase
        end
    end

    // Word and strobe land together on the second stop sample
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            data_out <= 9'd0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= (state == rx_stop2) && baud_tick;
            if (state == rx_stop2 && baud_tick && rx_sync && !frame_err) begin
                data_out <= {parity_on, shift_reg};  // Parity error still updates
            end
        end
    end

    assign uart_error = parity_err | frame_err;

endmodule

// ==== source/uart_driver.sv ====
`timescale 1ns/1ps

module uart_driver (
    input  logic       clk,
    input  logic       rst,
    input  logic       uart_start,  // Send strobe
    input  logic [8:0] data_in,     // Byte plus per-frame parity enable
    input  logic       parity_en,   // Receiver expects a parity bit
    input  logic       rx,
    output logic       tx,
    output logic [8:0] data_out,
    output logic       rx_valid,    // One cycle per received frame
    output logic       uart_ready,
    output logic       uart_busy,
    output logic       uart_error   // Parity or framing, held until next frame
);

    // Transmit half
    uart_tx u_tx (
        .clk        (clk),
        .rst        (rst),
        .uart_start (uart_start),
        .data_in    (data_in),
        .tx         (tx),
        .uart_ready (uart_ready),
        .uart_busy  (uart_busy)
    );

    // Receive half, shares only clock and reset with the transmitter
    uart_rx u_rx (
        .clk        (clk),
        .rst        (rst),
        .rx         (rx),
        .parity_en  (parity_en),
        .data_out   (data_out),
        .rx_valid   (rx_valid),
        .uart_error (uart_error)
    );

endmodule

// ==== dv/uart_driver_props.sv ====
`timescale 1ns/1ps

module uart_driver_props (
    input logic clk,
    input logic rst,
    input logic uart_start,
    input logic tx,
    input logic rx_valid,
    input logic uart_ready,
    input logic uart_busy
);

    int ready_busy_fails = 0;
    int valid_width_fails = 0;
    int idle_line_fails = 0;
    int busy_rise_fails = 0;
    int fail_count;

    assign fail_count = ready_busy_fails + valid_width_fails + idle_line_fails + busy_rise_fails;

    // Ready and busy both decode the idle state
    ready_busy_opposite: assert property (@(posedge clk) disable iff (rst)
        uart_ready != uart_busy)
    else begin
        ready_busy_fails++;
        $error("uart_ready and uart_busy are not opposite");
    end

    rx_valid_one_cycle: assert property (@(posedge clk) disable iff (rst)
        rx_valid |=> !rx_valid)
    else begin
        valid_width_fails++;
        $error("rx_valid stayed high for more than one cycle");
    end

    // Line rests high between frames
    tx_high_when_ready: assert property (@(posedge clk) disable iff (rst)
        uart_ready |-> tx)
    else begin
        idle_line_fails++;
        $error("tx is low while uart_ready is high");
    end

    busy_after_start: assert property (@(posedge clk) disable iff (rst)
        (uart_ready && uart_start) |=> uart_busy)
    else begin
        busy_rise_fails++;
        $error("uart_busy did not rise one cycle after an accepted strobe");
    end

endmodule

// ==== dv/uart_driver_tb.sv ====
`timescale 1ns/1ps

module uart_driver_tb;

    import uart_pkg::*;

    localparam int bit_cycles    = baud_div;
    localparam int glitch_cycles = baud_div_half - 8;  // Well under the mid-bit check
    localparam int cycle_limit   = 40 * 12 * baud_div + 2000;

    logic       clk;
    logic       rst;
    logic       uart_start;
    logic [8:0] data_in;
    logic       parity_en;
    logic       rx;
    logic       tx;
    logic [8:0] data_out;
    logic       rx_valid;
    logic       uart_ready;
    logic       uart_busy;
    logic       uart_error;

    logic       loopback;   // Line mux select
    logic       bang_line;
    logic [8:0] last_word;  // Word data_out should hold after a bad stop bit
    logic [31:0] rand_word;
    logic [8:0] exp_word;
    logic       exp_flag;
    int         seed;
    string      test_name;

    logic [8:0] exp_data[$];
    logic       exp_err[$];

    int rx_errors = 0;
    int seq_errors = 0;
    int cycle_count = 0;

    assign rx = loopback ? tx : bang_line;

    uart_driver dut (
        .clk        (clk),
        .rst        (rst),
        .uart_start (uart_start),
        .data_in    (data_in),
        .parity_en  (parity_en),
        .rx         (rx),
        .tx         (tx),
        .data_out   (data_out),
        .rx_valid   (rx_valid),
        .uart_ready (uart_ready),
        .uart_busy  (uart_busy),
        .uart_error (uart_error)
    );

    bind uart_driver uart_driver_props props (
        .clk        (clk),
        .rst        (rst),
        .uart_start (uart_start),
        .tx         (tx),
        .rx_valid   (rx_valid),
        .uart_ready (uart_ready),
        .uart_busy  (uart_busy)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count == cycle_limit) begin
            $display("Timeout after %0d cycles, a frame never completed", cycle_count);
            $display("sim failed");
            $finish;
        end
    end

    // Every received word is matched against the oldest frame sent
    always @(posedge clk) begin
        if (!rst && rx_valid) begin
            if (exp_data.size() == 0) begin
                $display("Unexpected rx_valid during %s, no frame was pending", test_name);
                rx_errors++;
            end else begin
                exp_word = exp_data.pop_front();
                exp_flag = exp_err.pop_front();
                assert (data_out == exp_word) else begin
                    $display("** Error %s: data_out expected %h, actual %h",
                             test_name, exp_word, data_out);
                    rx_errors++;
                end
                assert (uart_error == exp_flag) else begin
                    $display("** Error %s: uart_error expected %0b, actual %0b",
                             test_name, exp_flag, uart_error);
                    rx_errors++;
                end
            end
        end
    end

    task automatic check_level(input string what, input logic expected, input logic actual);
        assert (actual == expected) else begin
            $display("** Error %s: %s expected %0b, actual %0b",
                     test_name, what, expected, actual);
            seq_errors++;
        end
    endtask

    // Loopback frame through the transmitter
    task automatic send_word(input logic [8:0] word);
        while (!uart_ready) @(posedge clk);
        uart_start <= 1'b1;
        data_in    <= word;
        exp_data.push_back(word);
        exp_err.push_back(1'b0);
        last_word = word;
        @(posedge clk);
        uart_start <= 1'b0;
        @(posedge clk);
    endtask

    // Hand-built frame on the rx line
    task automatic bang_frame(input logic [7:0] value, input logic with_parity,
                              input logic parity_bit, input logic stop1);
        bang_line <= 1'b0;
        repeat (bit_cycles) @(posedge clk);
        check_level("uart_error after start bit", 1'b0, uart_error);
        for (int i = 0; i < 8; i++) begin
            bang_line <= value[i];
            repeat (bit_cycles) @(posedge clk);
        end
        if (with_parity) begin
            bang_line <= parity_bit;
            repeat (bit_cycles) @(posedge clk);
        end
        bang_line <= stop1;
        repeat (bit_cycles) @(posedge clk);
        bang_line <= 1'b1;
        repeat (bit_cycles) @(posedge clk);
    endtask

    task automatic wait_drain();
        while (exp_data.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);
    endtask

    initial begin
        seed       = 56199;
        rst        = 1'b1;
        uart_start = 1'b0;
        data_in    = 9'd0;
        parity_en  = 1'b0;
        loopback   = 1'b1;
        bang_line  = 1'b1;
        last_word  = 9'd0;
        test_name  = "reset";

        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_level("uart_ready", 1'b1, uart_ready);
        check_level("uart_busy", 1'b0, uart_busy);
        check_level("tx", 1'b1, tx);
        check_level("uart_error", 1'b0, uart_error);
        repeat (2 * bit_cycles) @(posedge clk);  // Idle line, monitor flags any pulse

        test_name = "loopback_no_parity";
        for (int i = 0; i < 12; i++) begin
            rand_word = $random(seed);
            send_word({1'b0, rand_word[7:0]});
        end
        wait_drain();

        test_name = "loopback_parity";
        parity_en <= 1'b1;
        @(posedge clk);
        for (int i = 0; i < 12; i++) begin
            rand_word = $random(seed);
            send_word({1'b1, rand_word[7:0]});
        end
        wait_drain();

        // Inverted parity bit, word still lands in data_out
        test_name = "parity_error";
        loopback <= 1'b0;
        rand_word = $random(seed);
        exp_data.push_back({1'b1, rand_word[7:0]});
        exp_err.push_back(1'b1);
        last_word = {1'b1, rand_word[7:0]};
        @(posedge clk);
        bang_frame(rand_word[7:0], 1'b1, ~(^rand_word[7:0]), 1'b1);
        wait_drain();
        repeat (bit_cycles) @(posedge clk);
        check_level("uart_error held after frame", 1'b1, uart_error);

        test_name = "framing_error";
        rand_word = $random(seed);
        exp_data.push_back(last_word);
        exp_err.push_back(1'b1);
        bang_frame(rand_word[7:0], 1'b1, ^rand_word[7:0], 1'b0);
        wait_drain();

        test_name = "false_start";
        parity_en <= 1'b0;
        bang_line <= 1'b0;
        repeat (glitch_cycles) @(posedge clk);
        bang_line <= 1'b1;
        repeat (2 * bit_cycles) @(posedge clk);
        loopback <= 1'b1;
        @(posedge clk);
        rand_word = $random(seed);
        send_word({1'b0, rand_word[7:0]});
        wait_drain();

        $display("Errors: %0d receive, %0d sequence, %0d assertion",
                 rx_errors, seq_errors, dut.props.fail_count);
        if (rx_errors == 0 && seq_errors == 0 && dut.props.fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
source/uart_pkg.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_driver.sv
dv/uart_driver_props.sv
dv/uart_driver_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the UART testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_LOG=build.log

rm -rf obj_dir "$LOG" "$BUILD_LOG"

verilator --binary --timing --assert --top-module uart_driver_tb \
    -f src.f -o uart_sim > "$BUILD_LOG" 2>&1 \
    || { cat "$BUILD_LOG"; echo "Build failed"; exit 1; }

# Keep running past assertion errors so the testbench prints its verdict
./obj_dir/uart_sim +verilator+error+limit+1000 > "$LOG" 2>&1
cat "$LOG"

grep -q "sim failed" "$LOG" && { echo "FAIL"; exit 1; }
grep -q "sim passed" "$LOG" || { echo "FAIL: no result line in $LOG"; exit 1; }
echo "PASS"
